// File: csi2LaneCapture.sv
module csi2LaneCapture
#(
  parameter int invertBits = 1
)
(
  input  logic                   CAM_CLOCK_I,
  input  logic                   RESET_n_I,
  input  csi2LanePkg::laneCountT numLanes_i,
  input  csi2LanePkg::laneByteT  channelA_i,
  input  csi2LanePkg::laneByteT  channelB_i,
  input  csi2LanePkg::laneByteT  channelC_i,
  input  csi2LanePkg::laneByteT  channelD_i,
  csi2LaneIf.capture             laneBus
);

  csi2LanePkg::laneCountT laneCount;
  logic [1:0]             paceCount;

  function automatic csi2LanePkg::laneByteT orderBits(input csi2LanePkg::laneByteT laneByte);
    if (invertBits != 0)
      orderBits = {<<{laneByte}};                   // Link sends LSB first
    else
      orderBits = laneByte;
  endfunction

  assign laneCount = csi2LanePkg::activeLanes(numLanes_i);

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      paceCount        <= 2'd0;
      laneBus.wordLoad <= 1'b0;
    end
    else
    begin
      if ({1'b0, paceCount} >= laneCount - 3'd1)
        paceCount <= 2'd0;
      else
        paceCount <= paceCount + 2'd1;
      laneBus.wordLoad <= (paceCount == 2'd0);
    end
  end

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (paceCount == 2'd0)                          // Sample slot
    begin
      laneBus.laneA <= orderBits(channelA_i);
      laneBus.laneB <= orderBits(channelB_i);
      laneBus.laneC <= orderBits(channelC_i);
      laneBus.laneD <= orderBits(channelD_i);
    end
  end

  laneCountLegal: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    numLanes_i inside {3'd1, 3'd2, 3'd4});

  laneCountStable: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    $past(RESET_n_I) |-> $stable(numLanes_i));

endmodule

// File: csi2LaneIf.sv
interface csi2LaneIf;

  csi2LanePkg::laneByteT laneA;
  csi2LanePkg::laneByteT laneB;
  csi2LanePkg::laneByteT laneC;
  csi2LanePkg::laneByteT laneD;
  logic                  wordLoad;                  // Fresh word in lane registers

  modport capture
  (
    output laneA, laneB, laneC, laneD, wordLoad
  );

  modport merger
  (
    input laneA, laneB, laneC, laneD, wordLoad
  );

endinterface

// File: csi2LaneMerger.sv
module csi2LaneMerger
(
  input  logic                     CAM_CLOCK_I,
  input  logic                     RESET_n_I,
  input  csi2LanePkg::laneCountT   numLanes_i,
  csi2LaneIf.merger                laneBus,
  output logic                     byteValid_o,
  output csi2PacketPkg::syncWindowT window_o
);

  csi2LanePkg::laneCountT laneCount;
  logic [1:0]             laneIndex;                // Zero when idle
  csi2LanePkg::laneByteT  storedB;
  csi2LanePkg::laneByteT  storedC;
  csi2LanePkg::laneByteT  storedD;
  csi2LanePkg::laneByteT  nextByte;

  assign laneCount = csi2LanePkg::activeLanes(numLanes_i);

  // Lane A goes straight through, the rest wait in the stored word
  always_comb
  begin
    if (laneBus.wordLoad)
      nextByte = laneBus.laneA;
    else
    begin
      case (laneIndex)
        2'd2: nextByte = storedC;
        2'd3: nextByte = storedD;
        default: nextByte = storedB;
      endcase
    end
  end

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (laneBus.wordLoad)
    begin
      storedB <= laneBus.laneB;
      storedC <= laneBus.laneC;
      storedD <= laneBus.laneD;
    end
  end

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      laneIndex    <= 2'd0;
      byteValid_o  <= 1'b0;
      window_o.raw <= 16'd0;                        // No stale sync match
    end
    else
    begin
      byteValid_o <= 1'b0;
      if (laneBus.wordLoad || laneIndex != 2'd0)
      begin
        byteValid_o                <= 1'b1;
        window_o.bytes.olderByte   <= window_o.bytes.newestByte;
        window_o.bytes.newestByte  <= nextByte;
        if ({1'b0, laneIndex} >= laneCount - 3'd1)
          laneIndex <= 2'd0;                        // Word done
        else
          laneIndex <= laneIndex + 2'd1;
      end
    end
  end

  // Capture pacing must leave room to serialize every lane
  noWordOverrun: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    laneBus.wordLoad |-> laneIndex == 2'd0);

endmodule

// File: csi2LanePkg.sv
`include "csi2Rx_macros.svh"

package csi2LanePkg;

  typedef logic [`CSI2_LANE_BITS-1:0] laneByteT;

  typedef logic [2:0] laneCountT;                   // 1, 2 or 4 lanes

  // Lane count actually used by the link
  function automatic laneCountT activeLanes(input laneCountT numLanes);
    case (numLanes)
      3'd2: activeLanes = 3'd2;
      3'd4: activeLanes = 3'd4;
      default: activeLanes = 3'd1;                  // Anything else runs as one lane
    endcase
  endfunction

endpackage

// File: csi2PacketParser.sv
`include "csi2Rx_macros.svh"

module csi2PacketParser
(
  input  logic                      CAM_CLOCK_I,
  input  logic                      RESET_n_I,
  input  logic                      byteValid_i,
  input  csi2PacketPkg::syncWindowT window_i,
  output csi2LanePkg::laneByteT     dataOut_o,
  output logic [15:0]               wordCount_o,
  output logic                      pixelValid_o,
  output logic                      frameStart_o,
  output logic                      frameEnd_o,
  output logic                      lineStart_o,
  output logic                      lineEnd_o,
  output logic [15:0]               frameNumber_o
);

  csi2PacketPkg::parseStateT parseState;
  csi2LanePkg::laneByteT     headerLo;              // Low byte of a two-byte field
  logic [15:0]               payloadCount;
  logic [7:0]                gapCount;

  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (byteValid_i)
    begin
      if (parseState == csi2PacketPkg::frameNumLo || parseState == csi2PacketPkg::wordCountLo)
        headerLo <= window_i.bytes.newestByte;
      if (parseState == csi2PacketPkg::payload)
        dataOut_o <= window_i.bytes.newestByte;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      parseState    <= csi2PacketPkg::huntFrame;
      payloadCount  <= 16'd0;
      gapCount      <= 8'd0;
      wordCount_o   <= 16'hFFFF;
      frameNumber_o <= 16'd0;
      pixelValid_o  <= 1'b0;
      frameStart_o  <= 1'b0;
      frameEnd_o    <= 1'b0;
      lineStart_o   <= 1'b0;
      lineEnd_o     <= 1'b0;
    end
    else
    begin
      pixelValid_o <= 1'b0;                         // Strobes last one cycle
      frameStart_o <= 1'b0;
      frameEnd_o   <= 1'b0;
      lineStart_o  <= 1'b0;
      lineEnd_o    <= 1'b0;
      if (byteValid_i)
      begin
        case (parseState)
          csi2PacketPkg::huntFrame:
            if (window_i.raw == `CSI2_FRAME_START_CODE)
              parseState <= csi2PacketPkg::frameNumLo;
          csi2PacketPkg::frameNumLo:
            parseState <= csi2PacketPkg::frameNumHi;
          csi2PacketPkg::frameNumHi:
          begin
            frameNumber_o <= {window_i.bytes.newestByte, headerLo};
            frameStart_o  <= 1'b1;
            parseState    <= csi2PacketPkg::huntLine;
          end
          csi2PacketPkg::huntLine:
          begin
            if (window_i.raw == `CSI2_FRAME_END_CODE)
            begin
              frameEnd_o <= 1'b1;
              gapCount   <= 8'd0;
              parseState <= csi2PacketPkg::frameGap;
            end
            else if (window_i.raw == `CSI2_LINE_START_CODE)
            begin
              lineStart_o <= 1'b1;
              parseState  <= csi2PacketPkg::wordCountLo;
            end
          end
          csi2PacketPkg::wordCountLo:
            parseState <= csi2PacketPkg::wordCountHi;
          csi2PacketPkg::wordCountHi:
          begin
            wordCount_o  <= {window_i.bytes.newestByte, headerLo};
            payloadCount <= 16'd0;
            gapCount     <= 8'd0;
            if ({window_i.bytes.newestByte, headerLo} == 16'd0)
            begin
              lineEnd_o  <= 1'b1;                   // Empty line
              parseState <= csi2PacketPkg::lineGap;
            end
            else
              parseState <= csi2PacketPkg::payload;
          end
          csi2PacketPkg::payload:
          begin
            pixelValid_o <= 1'b1;
            payloadCount <= payloadCount + 16'd1;
            if (payloadCount == wordCount_o - 16'd1)
            begin
              lineEnd_o  <= 1'b1;                   // With the last pixel
              parseState <= csi2PacketPkg::lineGap;
            end
          end
          csi2PacketPkg::lineGap:
          begin
            gapCount <= gapCount + 8'd1;
            if (gapCount == 8'(`CSI2_LINE_GAP - 1))
              parseState <= csi2PacketPkg::huntLine;
          end
          csi2PacketPkg::frameGap:
          begin
            gapCount <= gapCount + 8'd1;
            if (gapCount == 8'(`CSI2_FRAME_GAP - 1))
              parseState <= csi2PacketPkg::huntFrame;
          end
          default:
            parseState <= csi2PacketPkg::huntFrame;
        endcase
      end
    end
  end

  // Frame boundaries never overlap pixel data
  noPixelAtFrameEdge: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    pixelValid_o |-> !(frameStart_o || frameEnd_o));

endmodule

// File: csi2PacketPkg.sv
package csi2PacketPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Two-byte stream window
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    csi2LanePkg::laneByteT olderByte;
    csi2LanePkg::laneByteT newestByte;              // Last byte shifted in
  } windowBytesT;

  typedef union packed {
    logic [15:0] raw;                               // Compared against sync codes
    windowBytesT bytes;                             // Header field access
  } syncWindowT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet parser states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [3:0] {
    huntFrame,
    frameNumLo,
    frameNumHi,
    huntLine,
    wordCountLo,
    wordCountHi,
    payload,
    lineGap,
    frameGap
  } parseStateT;

endpackage

// File: csi2RxDecoder.f
+incdir+.
csi2LanePkg.sv
csi2PacketPkg.sv
csi2LaneIf.sv
csi2LaneCapture.sv
csi2LaneMerger.sv
csi2PacketParser.sv
csi2RxDecoder.sv
csi2RxMonitor.sv
csi2RxDecoderTb.sv

// File: csi2RxDecoder.sv
module csi2RxDecoder
#(
  parameter int invertBits = 1
)
(
  input  logic                   CAM_CLOCK_I,
  input  logic                   RESET_n_I,
  input  csi2LanePkg::laneCountT numLanes_i,
  input  csi2LanePkg::laneByteT  channelA_i,
  input  csi2LanePkg::laneByteT  channelB_i,
  input  csi2LanePkg::laneByteT  channelC_i,
  input  csi2LanePkg::laneByteT  channelD_i,
  output csi2LanePkg::laneByteT  dataOut_o,
  output logic [15:0]            wordCount_o,
  output logic                   pixelValid_o,
  output logic                   frameStart_o,
  output logic                   frameEnd_o,
  output logic                   lineStart_o,
  output logic                   lineEnd_o,
  output logic [15:0]            frameNumber_o
);

  csi2PacketPkg::syncWindowT window;
  logic                      byteValid;

  csi2LaneIf laneBus();

  csi2LaneCapture #(.invertBits(invertBits)) capture
  (
    .CAM_CLOCK_I (CAM_CLOCK_I),
    .RESET_n_I   (RESET_n_I),
    .numLanes_i  (numLanes_i),
    .channelA_i  (channelA_i),
    .channelB_i  (channelB_i),
    .channelC_i  (channelC_i),
    .channelD_i  (channelD_i),
    .laneBus     (laneBus.capture)
  );

  csi2LaneMerger merger
  (
    .CAM_CLOCK_I (CAM_CLOCK_I),
    .RESET_n_I   (RESET_n_I),
    .numLanes_i  (numLanes_i),
    .laneBus     (laneBus.merger),
    .byteValid_o (byteValid),
    .window_o    (window)
  );

  csi2PacketParser parser
  (
    .CAM_CLOCK_I   (CAM_CLOCK_I),
    .RESET_n_I     (RESET_n_I),
    .byteValid_i   (byteValid),
    .window_i      (window),
    .dataOut_o     (dataOut_o),
    .wordCount_o   (wordCount_o),
    .pixelValid_o  (pixelValid_o),
    .frameStart_o  (frameStart_o),
    .frameEnd_o    (frameEnd_o),
    .lineStart_o   (lineStart_o),
    .lineEnd_o     (lineEnd_o),
    .frameNumber_o (frameNumber_o)
  );

endmodule

// File: csi2RxDecoderTb.sv
`include "csi2Rx_macros.svh"

module csi2RxDecoderTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int invertBits    = 1;
  localparam int framesPerRun  = 3;
  localparam int linesPerFrame = 4;
  localparam int maxWordCount  = 20;
  localparam int leadBytes     = 4;                 // Idle bytes before the first frame
  localparam int resetCycles   = 10;
  localparam int maxRunBytes   = leadBytes + framesPerRun * (6 + `CSI2_FRAME_GAP + 1 +
                                 linesPerFrame * (4 + maxWordCount + `CSI2_LINE_GAP));
  localparam int timeoutCycles = 3 * (8 * maxRunBytes + resetCycles + 300);

  logic                   CAM_CLOCK_I = 1'b0;
  logic                   RESET_n_I = 1'b0;
  csi2LanePkg::laneCountT numLanes = 3'd1;
  csi2LanePkg::laneByteT  channelA = 8'h00;
  csi2LanePkg::laneByteT  channelB = 8'h00;
  csi2LanePkg::laneByteT  channelC = 8'h00;
  csi2LanePkg::laneByteT  channelD = 8'h00;
  logic                   syncSent = 1'b0;
  csi2LanePkg::laneByteT  dataOut;
  logic [15:0]            wordCount;
  logic [15:0]            frameNumber;
  logic                   pixelValid;
  logic                   frameStart;
  logic                   frameEnd;
  logic                   lineStart;
  logic                   lineEnd;
  int                     protocolErrors;
  int                     dataErrors;
  int                     frameEnds;
  int                     pending;
  int                     streamErrors = 0;
  logic [7:0]             streamQ[$];               // Logical stream bytes in link order

  always #4 CAM_CLOCK_I = ~CAM_CLOCK_I;

  csi2RxDecoder #(.invertBits(invertBits)) uut
  (
    .CAM_CLOCK_I   (CAM_CLOCK_I),
    .RESET_n_I     (RESET_n_I),
    .numLanes_i    (numLanes),
    .channelA_i    (channelA),
    .channelB_i    (channelB),
    .channelC_i    (channelC),
    .channelD_i    (channelD),
    .dataOut_o     (dataOut),
    .wordCount_o   (wordCount),
    .pixelValid_o  (pixelValid),
    .frameStart_o  (frameStart),
    .frameEnd_o    (frameEnd),
    .lineStart_o   (lineStart),
    .lineEnd_o     (lineEnd),
    .frameNumber_o (frameNumber)
  );

  csi2RxMonitor mon
  (
    .CAM_CLOCK_I      (CAM_CLOCK_I),
    .RESET_n_I        (RESET_n_I),
    .syncSent_i       (syncSent),
    .dataOut_i        (dataOut),
    .wordCount_i      (wordCount),
    .pixelValid_i     (pixelValid),
    .frameStart_i     (frameStart),
    .frameEnd_i       (frameEnd),
    .lineStart_i      (lineStart),
    .lineEnd_i        (lineEnd),
    .frameNumber_i    (frameNumber),
    .protocolErrors_o (protocolErrors),
    .dataErrors_o     (dataErrors),
    .frameEnds_o      (frameEnds),
    .pending_o        (pending)
  );

  function automatic logic [7:0] reverseByte(input logic [7:0] value);
    logic [7:0] result;
    for (int i = 0; i < 8; i++)
      result[i] = value[7 - i];
    return result;
  endfunction

  // Byte as it appears on the wire
  function automatic logic [7:0] laneByteAt(input int index);
    logic [7:0] value;
    value = (index < streamQ.size()) ? streamQ[index] : 8'h00;
    return (invertBits != 0) ? reverseByte(value) : value;
  endfunction

  task automatic pushCode(input logic [15:0] code);
    streamQ.push_back(code[15:8]);
    streamQ.push_back(code[7:0]);
  endtask

  task automatic pushFill(input int count);
    repeat (count)
      streamQ.push_back(8'h00);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream generation and lane driving
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic buildStream();
    logic [15:0] number;
    logic [15:0] count;
    logic [7:0]  pixel;
    streamQ.delete();
    pushFill(leadBytes);
    for (int f = 0; f < framesPerRun; f++)
    begin
      number = 16'($urandom);
      pushCode(`CSI2_FRAME_START_CODE);
      pushCode({number[7:0], number[15:8]});       // Low byte first
      mon.frameSent(number);
      for (int l = 0; l < linesPerFrame; l++)
      begin
        count = 16'($urandom_range(maxWordCount, 1));
        pushCode(`CSI2_LINE_START_CODE);
        pushCode({count[7:0], count[15:8]});
        mon.lineSent(count);
        for (int p = 0; p < int'(count); p++)
        begin
          pixel = 8'($urandom);
          streamQ.push_back(pixel);
          mon.pixelSent(pixel);
        end
        pushFill(`CSI2_LINE_GAP);
      end
      pushCode(`CSI2_FRAME_END_CODE);
      pushFill(`CSI2_FRAME_GAP + 1);
    end
  endtask

  task automatic runLanes(input csi2LanePkg::laneCountT lanes);
    int words;
    int base;
    int waitCycles;
    @(posedge CAM_CLOCK_I);
    RESET_n_I <= 1'b0;
    numLanes  <= lanes;
    syncSent  <= 1'b0;
    repeat (resetCycles) @(posedge CAM_CLOCK_I);
    buildStream();
    words = (streamQ.size() + int'(lanes) - 1) / int'(lanes);
    RESET_n_I <= 1'b1;
    for (int w = 0; w < words; w++)
    begin
      if (w > 0)
        repeat (lanes) @(posedge CAM_CLOCK_I);     // One word per sample slot
      base = w * int'(lanes);
      channelA <= laneByteAt(base);
      channelB <= (lanes >= 3'd2) ? laneByteAt(base + 1) : 8'h00;
      channelC <= (lanes == 3'd4) ? laneByteAt(base + 2) : 8'h00;
      channelD <= (lanes == 3'd4) ? laneByteAt(base + 3) : 8'h00;
      if (base + int'(lanes) > leadBytes)
        syncSent <= 1'b1;
    end
    waitCycles = 0;
    while (frameEnds < framesPerRun && waitCycles < 200)
    begin
      @(posedge CAM_CLOCK_I);
      waitCycles++;
    end
    assert (frameEnds == framesPerRun)
    else
    begin
      streamErrors++;
      $display("Mismatch frameEnd_o pulses with %0d lanes: got %h, expected %h",
               lanes, frameEnds, framesPerRun);
    end
    assert (pending == 0)
    else
    begin
      streamErrors++;
      $display("%0d sent frames, lines or pixels never came out with %0d lanes", pending, lanes);
    end
  endtask

  initial
  begin
    void'($urandom(32'heb4f_d646));
    runLanes(3'd1);
    runLanes(3'd2);
    runLanes(3'd4);
    $display("Errors: protocol %0d, data %0d, stream %0d", protocolErrors, dataErrors,
             streamErrors);
    if (protocolErrors + dataErrors + streamErrors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(timeoutCycles * 8);
    $display("Watchdog expired after %0d cycles before all runs finished", timeoutCycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: csi2RxMonitor.sv
module csi2RxMonitor
(
  input  logic                  CAM_CLOCK_I,
  input  logic                  RESET_n_I,
  input  logic                  syncSent_i,         // First frame sync is on the lanes
  input  csi2LanePkg::laneByteT dataOut_i,
  input  logic [15:0]           wordCount_i,
  input  logic                  pixelValid_i,
  input  logic                  frameStart_i,
  input  logic                  frameEnd_i,
  input  logic                  lineStart_i,
  input  logic                  lineEnd_i,
  input  logic [15:0]           frameNumber_i,
  output int                    protocolErrors_o,
  output int                    dataErrors_o,
  output int                    frameEnds_o,
  output int                    pending_o           // Expected items not yet produced
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0]           frameQ[$];
  logic [15:0]           wordQ[$];
  csi2LanePkg::laneByteT pixelQ[$];
  logic                  inFrame = 1'b0;
  int                    pixelCount = 0;
  int                    protocolErrors = 0;
  int                    dataErrors = 0;
  int                    frameEnds = 0;
  int                    pending = 0;

  assign protocolErrors_o = protocolErrors;
  assign dataErrors_o     = dataErrors;
  assign frameEnds_o      = frameEnds;
  assign pending_o        = pending;

  task automatic frameSent(input logic [15:0] number);
    frameQ.push_back(number);
  endtask

  task automatic lineSent(input logic [15:0] count);
    wordQ.push_back(count);
  endtask

  task automatic pixelSent(input csi2LanePkg::laneByteT pixel);
    pixelQ.push_back(pixel);
  endtask

  task automatic flagError(input string msg);
    dataErrors++;
    $display("%s", msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Protocol checks on the rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  quietBeforeSync: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    !syncSent_i |-> !(pixelValid_i || frameStart_i || frameEnd_i || lineStart_i || lineEnd_i))
  else
  begin
    protocolErrors++;
    $display("An output strobe was raised before any frame sync was sent, at %0t", $time);
  end

  resetValues: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    !syncSent_i |-> (wordCount_i == 16'hFFFF && frameNumber_i == 16'h0000))
  else
  begin
    protocolErrors++;
    $display("Mismatch wordCount_o/frameNumber_o after reset: got %h/%h, expected ffff/0000",
             $sampled(wordCount_i), $sampled(frameNumber_i));
  end

  lineInFrame: assert property (@(posedge CAM_CLOCK_I) disable iff (!RESET_n_I)
    lineStart_i |-> inFrame)
  else
  begin
    protocolErrors++;
    $display("lineStart_o was raised outside a frame, at %0t", $time);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference counters and data checks, mid-cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge CAM_CLOCK_I)
  begin
    if (!RESET_n_I)
    begin
      inFrame = 1'b0;
      pixelCount = 0;
      frameEnds = 0;
      frameQ.delete();
      wordQ.delete();
      pixelQ.delete();
    end
    else
    begin
      if (frameStart_i)
      begin
        inFrame = 1'b1;
        if (frameQ.size() == 0)
          flagError("frameStart_o was raised with no frame header left to expect");
        else
        begin
          assert (frameNumber_i == frameQ[0])
          else
            flagError($sformatf("Mismatch frameNumber_o: got %h, expected %h",
                                frameNumber_i, frameQ[0]));
          void'(frameQ.pop_front());
        end
      end
      if (lineStart_i)
        pixelCount = 0;
      if (pixelValid_i)
      begin
        pixelCount++;
        if (pixelQ.size() == 0)
          flagError("pixelValid_o was raised with no payload byte left to expect");
        else
        begin
          assert (dataOut_i == pixelQ[0])
          else
            flagError($sformatf("Mismatch dataOut_o: got %h, expected %h", dataOut_i, pixelQ[0]));
          void'(pixelQ.pop_front());
        end
      end
      if (lineEnd_i)
      begin
        assert (pixelCount == int'(wordCount_i))
        else
          flagError($sformatf("Mismatch wordCount_o: got %h, pixels counted %h",
                              wordCount_i, pixelCount));
        if (wordQ.size() == 0)
          flagError("lineEnd_o was raised with no line left to expect");
        else
        begin
          assert (wordCount_i == wordQ[0])
          else
            flagError($sformatf("Mismatch wordCount_o: got %h, expected %h", wordCount_i, wordQ[0]));
          void'(wordQ.pop_front());
        end
      end
      if (frameEnd_i)
      begin
        inFrame = 1'b0;
        frameEnds++;
      end
    end
    pending = frameQ.size() + wordQ.size() + pixelQ.size();
  end

endmodule

// File: csi2Rx_macros.svh
`ifndef CSI2RX_MACROS_SVH
`define CSI2RX_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sync codes as seen in the 16-bit stream window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CSI2_FRAME_START_CODE 16'hB800
`define CSI2_FRAME_END_CODE   16'hB801
`define CSI2_LINE_START_CODE  16'hB82A

// Width of one lane byte
`define CSI2_LANE_BITS 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream bytes skipped after a line and after a frame end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CSI2_LINE_GAP  3
`define CSI2_FRAME_GAP 3

`endif

// File: runSim.sh
#!/usr/bin/env bash
# Builds the csi2RxDecoder testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f csi2RxDecoder.f --top-module csi2RxDecoderTb -o csi2RxDecoderSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csi2RxDecoderSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^Test completed successfully$" "$logFile"; then
  exit 0
fi
exit 1
